/* logic/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // Backend sizes
    localparam int rob_entries = 8;
    localparam int word_size   = 32;
    localparam int rob_id_w    = 3;
    localparam int reg_idx_w   = 5;
    localparam int mem_words   = 64;

    // Unit latencies in cycles, issue to writeback
    localparam int alu_latency = 1;
    localparam int mul_latency = 3;

    typedef logic [word_size-1:0] word_t;
    typedef logic [rob_id_w-1:0]  rob_id_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_add,
        op_addi,
        op_mul,
        op_load,
        op_store
    } op_e;

    // Exception cause carried per ROB entry
    typedef enum logic [1:0] {
        fault_none,
        fault_fetch,
        fault_mem
    } fault_e;

endpackage

`default_nettype wire

/* logic/wb_if.sv */
`default_nettype none

interface wb_if;
    import rob_pkg::*;

    logic    valid;
    rob_id_t rob_id;
    word_t   result;
    fault_e  fault;
    // Faulting address, only meaningful for the memory unit
    word_t   fault_addr;

    modport unit (
        output valid,
        output rob_id,
        output result,
        output fault,
        output fault_addr
    );

    modport rob (
        input valid,
        input rob_id,
        input result,
        input fault,
        input fault_addr
    );

endinterface

`default_nettype wire

/* logic/rob.sv */
`default_nettype none

module rob (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  rob_pkg::reg_idx_t alloc_rd,
    input  logic              alloc_is_store,
    input  rob_pkg::word_t    alloc_pc,
    input  logic              alloc_fetch_fault,
    output rob_pkg::rob_id_t  alloc_id,
    output logic              full,
    output logic              halted,
    wb_if.rob                 alu_wb,
    wb_if.rob                 mul_wb,
    wb_if.rob                 mem_wb,
    input  rob_pkg::rob_id_t  byp1_id,
    input  rob_pkg::rob_id_t  byp2_id,
    output logic              byp1_ready,
    output rob_pkg::word_t    byp1_value,
    output logic              byp2_ready,
    output rob_pkg::word_t    byp2_value,
    output logic              commit,
    output rob_pkg::reg_idx_t commit_rd,
    output rob_pkg::word_t    commit_value,
    output rob_pkg::rob_id_t  commit_id,
    output logic              sb_release,
    output rob_pkg::rob_id_t  sb_id,
    output logic              exception,
    output rob_pkg::word_t    ex_pc,
    output rob_pkg::fault_e   ex_cause,
    output rob_pkg::word_t    ex_addr
);
    import rob_pkg::*;

    // Entry storage
    reg_idx_t   rd_q       [rob_entries];
    word_t      value_q    [rob_entries];
    word_t      pc_q       [rob_entries];
    fault_e     fault_q    [rob_entries];
    word_t      fault_addr [rob_entries];
    logic [rob_entries-1:0] ready_q;
    logic [rob_entries-1:0] store_q;

    rob_id_t          head;
    rob_id_t          tail;
    logic [rob_id_w:0] count;

    // Writeback ports gathered for one loop
    logic [2:0] wb_v;
    rob_id_t    wb_id   [3];
    word_t      wb_res  [3];
    fault_e     wb_flt  [3];
    word_t      wb_addr [3];

    logic head_ready;
    logic head_fault;

    always_comb begin
        wb_v       = {mem_wb.valid, mul_wb.valid, alu_wb.valid};
        wb_id[0]   = alu_wb.rob_id;
        wb_id[1]   = mul_wb.rob_id;
        wb_id[2]   = mem_wb.rob_id;
        wb_res[0]  = alu_wb.result;
        wb_res[1]  = mul_wb.result;
        wb_res[2]  = mem_wb.result;
        wb_flt[0]  = alu_wb.fault;
        wb_flt[1]  = mul_wb.fault;
        wb_flt[2]  = mem_wb.fault;
        wb_addr[0] = alu_wb.fault_addr;
        wb_addr[1] = mul_wb.fault_addr;
        wb_addr[2] = mem_wb.fault_addr;
    end

    assign full     = (count == (rob_id_w + 1)'(rob_entries));
    assign alloc_id = tail;
    assign halted   = exception;

    // Head state drives commit, store release and exceptions
    assign head_ready = (count != '0) && ready_q[head];
    assign head_fault = (fault_q[head] != fault_none);

    assign commit       = head_ready && !head_fault && !exception;
    assign commit_rd    = rd_q[head];
    assign commit_value = value_q[head];
    assign commit_id    = head;

    // Store may write memory only once it is the committing head
    assign sb_release = commit && store_q[head];
    assign sb_id      = head;

    // Operand bypass straight from entry state
    assign byp1_ready = ready_q[byp1_id];
    assign byp1_value = value_q[byp1_id];
    assign byp2_ready = ready_q[byp2_id];
    assign byp2_value = value_q[byp2_id];

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ready_q   <= '0;
            exception <= 1'b0;
            ex_pc     <= '0;
            ex_cause  <= fault_none;
            ex_addr   <= '0;
        end else begin
            // Retire head
            if (commit) begin
                ready_q[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            // Oldest fault reaches head, freeze the backend
            if (head_ready && head_fault && !exception) begin
                exception <= 1'b1;
                ex_pc     <= pc_q[head];
                ex_cause  <= fault_q[head];
                ex_addr   <= fault_addr[head];
            end
            // New entry at tail
            if (alloc) begin
                rd_q[tail]       <= alloc_rd;
                store_q[tail]    <= alloc_is_store;
                pc_q[tail]       <= alloc_pc;
                // Fetch faults are complete on arrival
                ready_q[tail]    <= alloc_fetch_fault;
                fault_q[tail]    <= alloc_fetch_fault ? fault_fetch : fault_none;
                fault_addr[tail] <= alloc_pc;
                tail             <= tail + 1'b1;
            end
            for (int p = 0; p < 3; p++) begin
                if (wb_v[p]) begin
                    ready_q[wb_id[p]]    <= 1'b1;
                    value_q[wb_id[p]]    <= wb_res[p];
                    fault_q[wb_id[p]]    <= wb_flt[p];
                    fault_addr[wb_id[p]] <= wb_addr[p];
                end
            end
            case ({alloc, commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/reg_rename.sv */
`default_nettype none

module reg_rename (
    input  logic              clk,
    input  logic              rst,
    input  rob_pkg::reg_idx_t rs1,
    input  rob_pkg::reg_idx_t rs2,
    output logic              src1_pending,
    output rob_pkg::rob_id_t  src1_id,
    output rob_pkg::word_t    src1_value,
    output logic              src2_pending,
    output rob_pkg::rob_id_t  src2_id,
    output rob_pkg::word_t    src2_value,
    input  logic              ren_we,
    input  rob_pkg::reg_idx_t ren_rd,
    input  rob_pkg::rob_id_t  ren_id,
    input  logic              commit,
    input  rob_pkg::reg_idx_t commit_rd,
    input  rob_pkg::word_t    commit_value,
    input  rob_pkg::rob_id_t  commit_id
);
    import rob_pkg::*;

    // Architectural state
    word_t   regs    [32];
    // Rename table, newest producer per register
    logic [31:0] pending;
    rob_id_t map     [32];

    // Register 0 is hardwired zero and never renamed
    assign src1_pending = (rs1 != '0) && pending[rs1];
    assign src1_id      = map[rs1];
    assign src1_value   = (rs1 == '0) ? '0 : regs[rs1];
    assign src2_pending = (rs2 != '0) && pending[rs2];
    assign src2_id      = map[rs2];
    assign src2_value   = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (commit && commit_rd != '0) begin
                regs[commit_rd] <= commit_value;
                // Clear only if no younger producer took the register
                if (map[commit_rd] == commit_id) begin
                    pending[commit_rd] <= 1'b0;
                end
            end
            // Later assignment wins over the commit clear
            if (ren_we && ren_rd != '0) begin
                pending[ren_rd] <= 1'b1;
                map[ren_rd]     <= ren_id;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/exec_pipe.sv */
`default_nettype none

module exec_pipe #(
    parameter int LATENCY = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  rob_pkg::op_e     op,
    input  rob_pkg::word_t   a,
    input  rob_pkg::word_t   b,
    input  rob_pkg::word_t   imm,
    input  rob_pkg::rob_id_t issue_id,
    wb_if.unit               wb
);
    import rob_pkg::*;

    logic [LATENCY-1:0] stage_v;
    word_t              stage_res [LATENCY];
    rob_id_t            stage_id  [LATENCY];
    word_t              result;

    always_comb begin
        case (op)
            op_addi: result = a + imm;
            // Low half of the product
            op_mul:  result = a * b;
            default: result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_v <= '0;
        end else begin
            stage_v[0] <= issue;
            for (int s = 1; s < LATENCY; s++) begin
                stage_v[s] <= stage_v[s-1];
            end
        end
    end

    // Payload shifts without reset
    always_ff @(posedge clk) begin
        stage_res[0] <= result;
        stage_id[0]  <= issue_id;
        for (int s = 1; s < LATENCY; s++) begin
            stage_res[s] <= stage_res[s-1];
            stage_id[s]  <= stage_id[s-1];
        end
    end

    assign wb.valid      = stage_v[LATENCY-1];
    assign wb.rob_id     = stage_id[LATENCY-1];
    assign wb.result     = stage_res[LATENCY-1];
    // Arithmetic never faults
    assign wb.fault      = fault_none;
    assign wb.fault_addr = '0;

endmodule

`default_nettype wire

/* logic/mem_unit.sv */
`default_nettype none

module mem_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  rob_pkg::op_e     op,
    input  rob_pkg::word_t   a,
    input  rob_pkg::word_t   b,
    input  rob_pkg::word_t   imm,
    input  rob_pkg::rob_id_t issue_id,
    wb_if.unit               wb,
    input  logic             sb_release,
    input  rob_pkg::rob_id_t sb_id,
    output logic             store_pending
);
    import rob_pkg::*;

    localparam int idx_w = $clog2(mem_words);

    word_t mem [mem_words];

    // Stage 1 address check
    word_t   addr;
    logic    addr_bad;
    logic    s1_valid;
    logic    s1_store;
    logic    s1_fault;
    word_t   s1_addr;
    word_t   s1_data;
    rob_id_t s1_id;

    // 4-deep store queue, in program order
    logic [idx_w-1:0] sq_idx  [4];
    word_t            sq_data [4];
    rob_id_t          sq_id   [4];
    logic [1:0]       sq_head;
    logic [1:0]       sq_tail;
    logic [2:0]       sq_count;
    logic             sq_push;
    logic             sq_pop;

    assign addr     = a + imm;
    assign addr_bad = (addr[1:0] != 2'b00) || (addr >= word_t'(4 * mem_words));

    assign sq_push = s1_valid && s1_store && !s1_fault;
    assign sq_pop  = sb_release && (sq_count != '0) && (sq_id[sq_head] == sb_id);

    // Anything store-like not yet in memory
    assign store_pending = (s1_valid && s1_store) || (sq_count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            wb.valid <= 1'b0;
            sq_head  <= '0;
            sq_tail  <= '0;
            sq_count <= '0;
            for (int w = 0; w < mem_words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            s1_valid <= issue;
            wb.valid <= s1_valid;
            if (sq_push) begin
                sq_tail <= sq_tail + 1'b1;
            end
            // Released store drains into memory
            if (sq_pop) begin
                mem[sq_idx[sq_head]] <= sq_data[sq_head];
                sq_head              <= sq_head + 1'b1;
            end
            case ({sq_push, sq_pop})
                2'b10:   sq_count <= sq_count + 1'b1;
                2'b01:   sq_count <= sq_count - 1'b1;
                default: sq_count <= sq_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        s1_store <= (op == op_store);
        s1_fault <= addr_bad;
        s1_addr  <= addr;
        s1_data  <= b;
        s1_id    <= issue_id;
        // Stage 2, load read or queue push
        wb.rob_id     <= s1_id;
        wb.result     <= s1_store ? '0 : mem[s1_addr[idx_w+1:2]];
        wb.fault      <= s1_fault ? fault_mem : fault_none;
        wb.fault_addr <= s1_addr;
        if (sq_push) begin
            sq_idx[sq_tail]  <= s1_addr[idx_w+1:2];
            sq_data[sq_tail] <= s1_data;
            sq_id[sq_tail]   <= s1_id;
        end
    end

endmodule

`default_nettype wire

/* logic/dispatch.sv */
`default_nettype none

module dispatch (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  rob_pkg::op_e      in_op,
    input  rob_pkg::reg_idx_t in_rd,
    input  rob_pkg::reg_idx_t in_rs1,
    input  rob_pkg::reg_idx_t in_rs2,
    input  rob_pkg::word_t    in_imm,
    input  rob_pkg::word_t    in_pc,
    input  logic              in_fetch_fault,
    output rob_pkg::reg_idx_t rs1,
    output rob_pkg::reg_idx_t rs2,
    input  logic              src1_pending,
    input  rob_pkg::rob_id_t  src1_id,
    input  rob_pkg::word_t    src1_value,
    input  logic              src2_pending,
    input  rob_pkg::rob_id_t  src2_id,
    input  rob_pkg::word_t    src2_value,
    output logic              ren_we,
    output rob_pkg::reg_idx_t ren_rd,
    output rob_pkg::rob_id_t  ren_id,
    output logic              alloc,
    output rob_pkg::reg_idx_t alloc_rd,
    output logic              alloc_is_store,
    output rob_pkg::word_t    alloc_pc,
    output logic              alloc_fetch_fault,
    input  rob_pkg::rob_id_t  alloc_id,
    input  logic              full,
    input  logic              halted,
    output rob_pkg::rob_id_t  byp1_id,
    output rob_pkg::rob_id_t  byp2_id,
    input  logic              byp1_ready,
    input  rob_pkg::word_t    byp1_value,
    input  logic              byp2_ready,
    input  rob_pkg::word_t    byp2_value,
    output logic              alu_issue,
    output logic              mul_issue,
    output logic              mem_issue,
    output rob_pkg::op_e      op,
    output rob_pkg::word_t    a,
    output rob_pkg::word_t    b,
    output rob_pkg::word_t    imm,
    output rob_pkg::rob_id_t  issue_id,
    input  logic              store_pending
);
    import rob_pkg::*;

    logic live;
    logic is_store;
    logic is_mem;
    logic needs_rs2;
    logic op1_ok;
    logic op2_ok;
    logic accept;
    logic go;

    // Hold off for one cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign is_store  = (in_op == op_store);
    assign is_mem    = (in_op == op_load) || is_store;
    assign needs_rs2 = (in_op == op_add) || (in_op == op_mul) || is_store;

    // Operand lookup, renamed sources come from the ROB
    assign rs1     = in_rs1;
    assign rs2     = in_rs2;
    assign byp1_id = src1_id;
    assign byp2_id = src2_id;
    assign op1_ok  = !src1_pending || byp1_ready;
    assign op2_ok  = !needs_rs2 || !src2_pending || byp2_ready;
    assign a       = src1_pending ? byp1_value : src1_value;
    assign b       = src2_pending ? byp2_value : src2_value;

    // Memory ops wait out queued stores, which also bounds the queue
    assign in_ready = live && !full && !halted
                   && (in_fetch_fault || (op1_ok && op2_ok && !(is_mem && store_pending)));
    assign accept   = in_valid && in_ready;
    // Fetch faults take an entry but never issue
    assign go       = accept && !in_fetch_fault;

    assign alloc             = accept;
    assign alloc_rd          = is_store ? '0 : in_rd;
    assign alloc_is_store    = is_store;
    assign alloc_pc          = in_pc;
    assign alloc_fetch_fault = in_fetch_fault;

    assign ren_we = go && !is_store;
    assign ren_rd = in_rd;
    assign ren_id = alloc_id;

    // Route to a unit
    assign alu_issue = go && ((in_op == op_add) || (in_op == op_addi));
    assign mul_issue = go && (in_op == op_mul);
    assign mem_issue = go && is_mem;
    assign op        = in_op;
    assign imm       = in_imm;
    assign issue_id  = alloc_id;

endmodule

`default_nettype wire

/* logic/ooo_backend.sv */
`default_nettype none

module ooo_backend (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  rob_pkg::op_e      in_op,
    input  rob_pkg::reg_idx_t in_rd,
    input  rob_pkg::reg_idx_t in_rs1,
    input  rob_pkg::reg_idx_t in_rs2,
    input  rob_pkg::word_t    in_imm,
    input  rob_pkg::word_t    in_pc,
    input  logic              in_fetch_fault,
    output logic              commit_valid,
    output rob_pkg::reg_idx_t commit_rd,
    output rob_pkg::word_t    commit_value,
    output logic              exception,
    output rob_pkg::word_t    ex_pc,
    output rob_pkg::fault_e   ex_cause,
    output rob_pkg::word_t    ex_addr
);
    import rob_pkg::*;

    // Rename and operand lookup
    reg_idx_t rs1, rs2, ren_rd, alloc_rd;
    logic     src1_pending, src2_pending, ren_we;
    rob_id_t  src1_id, src2_id, ren_id;
    word_t    src1_value, src2_value;

    // ROB side
    logic     alloc, alloc_is_store, alloc_fetch_fault, full, halted;
    word_t    alloc_pc, byp1_value, byp2_value;
    rob_id_t  alloc_id, byp1_id, byp2_id, commit_id, sb_id;
    logic     byp1_ready, byp2_ready, sb_release;

    // Shared issue bus
    logic     alu_issue, mul_issue, mem_issue, store_pending;
    op_e      op;
    word_t    a, b, imm;
    rob_id_t  issue_id;

    wb_if alu_wb ();
    wb_if mul_wb ();
    wb_if mem_wb ();

    dispatch u_dispatch (.*);

    reg_rename u_rename (
        .commit(commit_valid),
        .*
    );

    rob u_rob (
        .commit(commit_valid),
        .*
    );

    exec_pipe #(.LATENCY(alu_latency)) u_alu (
        .issue(alu_issue),
        .wb(alu_wb),
        .*
    );

    exec_pipe #(.LATENCY(mul_latency)) u_mul (
        .issue(mul_issue),
        .wb(mul_wb),
        .*
    );

    mem_unit u_mem (
        .issue(mem_issue),
        .wb(mem_wb),
        .*
    );

endmodule

`default_nettype wire

/* dv/rob_checker.sv */
`default_nettype none

module rob_checker (
    input logic clk,
    input logic rst,
    input logic alloc,
    input logic full,
    input logic commit,
    input logic exception
);
    timeunit 1ns;
    timeprecision 1ps;

    // Running totals since reset, frozen once the backend halts
    int unsigned allocs;
    int unsigned commits;

    always_ff @(posedge clk) begin
        if (rst) begin
            allocs  <= 0;
            commits <= 0;
        end else if (!exception) begin
            allocs  <= allocs + alloc;
            commits <= commits + commit;
        end
    end

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst) !(full && alloc))
        else $error("ROB allocated an entry while full");

    no_commit_after_fault: assert property (@(posedge clk) disable iff (rst)
        !(commit && exception))
        else $error("ROB committed while exception was raised");

    // An entry cannot retire before it was allocated
    commits_bounded: assert property (@(posedge clk) disable iff (rst || exception)
        commits <= allocs)
        else $error("ROB retired more entries than it allocated");

endmodule

bind rob rob_checker u_rob_checker (
    .clk(clk),
    .rst(rst),
    .alloc(alloc),
    .full(full),
    .commit(commit),
    .exception(exception)
);

`default_nettype wire

/* dv/ooo_backend_tb.sv */
`default_nettype none

module ooo_backend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rob_pkg::*;

    // 71 instructions, a few cycles each at worst, plus resets and drain time
    localparam int max_cycles = 71 * 12 + 3 * 20 + 100;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    op_e      in_op;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    word_t    in_imm;
    word_t    in_pc;
    logic     in_fetch_fault;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     exception;
    word_t    ex_pc;
    fault_e   ex_cause;
    word_t    ex_addr;

    // Program under test
    op_e      prog_op  [64];
    reg_idx_t prog_rd  [64];
    reg_idx_t prog_rs1 [64];
    reg_idx_t prog_rs2 [64];
    word_t    prog_imm [64];
    word_t    prog_pc  [64];
    logic     prog_ff  [64];

    // Expected retirement stream and fault
    reg_idx_t exp_rd    [$];
    word_t    exp_val   [$];
    logic     exp_store [$];
    logic     exp_fault;
    fault_e   exp_cause;
    word_t    exp_pc;
    word_t    exp_addr;

    logic [15:0] lfsr_state;
    string       test_name;
    int          checks;
    int          errors;
    int          cycles;

    ooo_backend u_dut (.*);

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Run stopped after %0d cycles with tests still open", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic put_instr(input int i, input word_t base, input op_e op, input reg_idx_t rd,
                             input reg_idx_t rs1, input reg_idx_t rs2, input word_t imm,
                             input logic ff);
        prog_op[i]  = op;
        prog_rd[i]  = rd;
        prog_rs1[i] = rs1;
        prog_rs2[i] = rs2;
        prog_imm[i] = imm;
        prog_pc[i]  = base + 4 * i;
        prog_ff[i]  = ff;
    endtask

    task automatic build_random(input int n);
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        for (int i = 0; i < n; i++) begin
            // Few registers so dependencies are frequent
            rd  = reg_idx_t'(1 + take_bits(3) % 7);
            rs1 = reg_idx_t'(take_bits(3));
            rs2 = reg_idx_t'(take_bits(3));
            imm = take_bits(8);
            case (take_bits(3))
                0, 1:    op = op_add;
                2:       op = op_addi;
                3, 4:    op = op_mul;
                5:       op = op_load;
                default: op = op_store;
            endcase
            // Long multiply run
            if (i >= 24 && i < 36) begin
                op = op_mul;
            end
            // Add consuming the last multiply
            if (i == 36) begin
                op  = op_add;
                rs1 = prog_rd[35];
            end
            // Aligned, in range, over 8 words so loads hit stores
            if (op == op_load || op == op_store) begin
                rs1 = '0;
                imm = take_bits(3) << 2;
            end
            put_instr(i, 32'h100, op, rd, rs1, rs2, imm, 1'b0);
        end
    endtask

    // Sequential model of the program
    function automatic void run_reference(input int n);
        word_t regs [32];
        word_t mem  [mem_words];
        word_t addr;
        word_t val;
        logic  st;
        exp_rd.delete();
        exp_val.delete();
        exp_store.delete();
        exp_fault = 1'b0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < mem_words; w++) begin
            mem[w] = '0;
        end
        for (int i = 0; i < n; i++) begin
            if (prog_ff[i]) begin
                exp_fault = 1'b1;
                exp_cause = fault_fetch;
                exp_pc    = prog_pc[i];
                exp_addr  = prog_pc[i];
                return;
            end
            st   = (prog_op[i] == op_store);
            addr = regs[prog_rs1[i]] + prog_imm[i];
            val  = '0;
            case (prog_op[i])
                op_add:  val = regs[prog_rs1[i]] + regs[prog_rs2[i]];
                op_addi: val = regs[prog_rs1[i]] + prog_imm[i];
                op_mul:  val = regs[prog_rs1[i]] * regs[prog_rs2[i]];
                default: begin
                    if (addr[1:0] != 2'b00 || addr >= word_t'(4 * mem_words)) begin
                        exp_fault = 1'b1;
                        exp_cause = fault_mem;
                        exp_pc    = prog_pc[i];
                        exp_addr  = addr;
                        return;
                    end
                    if (st) begin
                        mem[addr >> 2] = regs[prog_rs2[i]];
                    end else begin
                        val = mem[addr >> 2];
                    end
                end
            endcase
            // Stores retire without a destination
            exp_rd.push_back(st ? reg_idx_t'(0) : prog_rd[i]);
            exp_val.push_back(val);
            exp_store.push_back(st);
            if (!st && prog_rd[i] != '0) begin
                regs[prog_rd[i]] = val;
            end
        end
    endfunction

    // Retirement stream compare
    always @(negedge clk) begin : compare_commits
        reg_idx_t rd_e;
        word_t    val_e;
        logic     st_e;
        if (!rst && commit_valid) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("%s: commit of rd %0d with no instruction left to retire",
                         test_name, commit_rd);
            end else begin
                rd_e  = exp_rd.pop_front();
                val_e = exp_val.pop_front();
                st_e  = exp_store.pop_front();
                check("commit_rd", rd_e, commit_rd);
                if (!st_e) begin
                    check("commit_value", val_e, commit_value);
                end
            end
        end
    end

    task automatic reset_dut();
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Hold each instruction until accepted, stop feeding once halted
    task automatic send_program(input int n);
        for (int i = 0; i < n; i++) begin
            in_valid       <= 1'b1;
            in_op          <= prog_op[i];
            in_rd          <= prog_rd[i];
            in_rs1         <= prog_rs1[i];
            in_rs2         <= prog_rs2[i];
            in_imm         <= prog_imm[i];
            in_pc          <= prog_pc[i];
            in_fetch_fault <= prog_ff[i];
            @(posedge clk);
            while (!in_ready && !exception) begin
                @(posedge clk);
            end
            if (exception) begin
                break;
            end
        end
        in_valid       <= 1'b0;
        in_fetch_fault <= 1'b0;
    endtask

    task automatic wait_done();
        while (exp_rd.size() != 0 || (exp_fault && !exception)) begin
            @(posedge clk);
        end
        // Window for stray younger commits
        repeat (10) @(posedge clk);
    endtask

    task automatic run_test(input string name, input int n);
        test_name = name;
        reset_dut();
        run_reference(n);
        send_program(n);
        wait_done();
        check("exception", exp_fault, exception);
        if (exp_fault) begin
            check("ex_cause", exp_cause, ex_cause);
            check("ex_pc", exp_pc, ex_pc);
            if (exp_cause == fault_mem) begin
                check("ex_addr", exp_addr, ex_addr);
            end
        end
    endtask

    initial begin
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_op          = op_add;
        in_rd          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_imm         = '0;
        in_pc          = '0;
        in_fetch_fault = 1'b0;
        lfsr_state     = 16'd20;
        checks         = 0;
        errors         = 0;
        cycles         = 0;

        // Mixed program: order, chains, store/load, multiply run
        build_random(60);
        run_test("random_program", 60);

        // Misaligned load with a younger store behind it
        put_instr(0, 32'h200, op_addi,  5'd1, 5'd0, 5'd0, 32'h55, 1'b0);
        put_instr(1, 32'h200, op_store, 5'd0, 5'd0, 5'd1, 32'h8,  1'b0);
        put_instr(2, 32'h200, op_load,  5'd2, 5'd0, 5'd0, 32'h8,  1'b0);
        put_instr(3, 32'h200, op_mul,   5'd3, 5'd1, 5'd2, 32'h0,  1'b0);
        put_instr(4, 32'h200, op_load,  5'd4, 5'd0, 5'd0, 32'h16, 1'b0);
        put_instr(5, 32'h200, op_store, 5'd0, 5'd0, 5'd3, 32'hC,  1'b0);
        put_instr(6, 32'h200, op_addi,  5'd5, 5'd0, 5'd0, 32'h1,  1'b0);
        run_test("mem_fault", 7);
        check("younger store word", 32'h0, u_dut.u_mem.mem[3]);

        // Fetch fault after a load of that same word
        put_instr(0, 32'h300, op_addi, 5'd1, 5'd0, 5'd0, 32'h7, 1'b0);
        put_instr(1, 32'h300, op_load, 5'd2, 5'd0, 5'd0, 32'hC, 1'b0);
        put_instr(2, 32'h300, op_addi, 5'd3, 5'd1, 5'd0, 32'h2, 1'b1);
        put_instr(3, 32'h300, op_addi, 5'd4, 5'd1, 5'd0, 32'h3, 1'b0);
        run_test("fetch_fault", 4);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_backend.f */
logic/rob_pkg.sv
logic/wb_if.sv
logic/rob.sv
logic/reg_rename.sv
logic/exec_pipe.sv
logic/mem_unit.sv
logic/dispatch.sv
logic/ooo_backend.sv
dv/rob_checker.sv
dv/ooo_backend_tb.sv
